//--- Makefile
# Verilator build and run for the completion stage testbench

.PHONY: all run lint clean

all: run

obj_dir/Vcompletion_stage_tb: sources.f $(wildcard logic/*.sv tests/*.sv)
	verilator --binary --timing -Wno-fatal -f sources.f \
		--top-module completion_stage_tb -o Vcompletion_stage_tb

# the log decides pass or fail
run: obj_dir/Vcompletion_stage_tb
	-./obj_dir/Vcompletion_stage_tb > sim.log 2>&1
	cat sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module completion_stage_tb

clean:
	rm -rf obj_dir sim.log

//--- logic/cdb_arbiter.sv
`timescale 1ns/10ps

// picks up to cdb_ports held results per cycle for the bus and rob
// conditional branches skip the bus and go out on branch_packet
module cdb_arbiter import fu_packets_pkg::*; (
  input  logic [num_fu_alu-1:0] alu_prepared,
  input  logic [num_fu_mult-1:0] mult_prepared,
  input  logic [num_fu_load-1:0] load_prepared,
  input  alu_result_t [num_fu_alu-1:0] alu_held,
  input  fu_result_t [num_fu_mult-1:0] mult_held,
  input  fu_result_t [num_fu_load-1:0] load_held,
  output logic [num_fu_alu-1:0] alu_avail,
  output logic [num_fu_mult-1:0] mult_avail,
  output logic [num_fu_load-1:0] load_avail,
  output branch_packet_t [num_fu_alu-1:0] branch_packet,
  output fu_rob_packet_t [cdb_ports-1:0] fu_rob_packet,
  output cdb_packet_t [cdb_ports-1:0] cdb_output
);

  logic [num_fu_alu-1:0] cond_branch;
  logic [num_fu-1:0] req;
  logic [num_fu-1:0] gnt;
  logic [cdb_ports-1:0][num_fu-1:0] gnt_bus;

  // per-lane candidates in request-vector order
  fu_rob_packet_t [num_fu-1:0] rob_cand;
  cdb_packet_t [num_fu-1:0] bus_cand;

  // branch flag of each alu lane
  always_comb begin
    for (int i = 0; i < num_fu_alu; i++) begin
      cond_branch[i] = alu_held[i].cond_branch;
    end
  end

  // loads low then mult with alu on top
  // branches never ask for the bus
  assign req[load_base +: num_fu_load] = load_prepared;
  assign req[mult_base +: num_fu_mult] = mult_prepared;
  assign req[alu_base +: num_fu_alu] = alu_prepared & ~cond_branch;

  psel_gen #(
    .WIDTH(num_fu),
    .REQS (cdb_ports)
  ) psel_i (
    .req    (req),
    .gnt    (gnt),
    .gnt_bus(gnt_bus),
    .empty  ()
  );

  // slot may reload when drained now or empty or holding a branch
  assign load_avail = gnt[load_base +: num_fu_load] | ~load_prepared;
  assign mult_avail = gnt[mult_base +: num_fu_mult] | ~mult_prepared;
  assign alu_avail = gnt[alu_base +: num_fu_alu] | ~alu_prepared | cond_branch;

  // candidates for all lanes
  // load and mult lanes have no branch info so their target stays zero
  always_comb begin
    for (int i = 0; i < num_fu_load; i++) begin
      rob_cand[load_base+i].robn = load_held[i].robn;
      rob_cand[load_base+i].executed = load_prepared[i];
      rob_cand[load_base+i].branch_taken = 1'b0;
      rob_cand[load_base+i].target_addr = '0;
      bus_cand[load_base+i] = '0;
      if (load_prepared[i]) begin
        bus_cand[load_base+i].dest_prn = load_held[i].dest_prn;
        bus_cand[load_base+i].value = load_held[i].result;
      end
    end
    for (int i = 0; i < num_fu_mult; i++) begin
      rob_cand[mult_base+i].robn = mult_held[i].robn;
      rob_cand[mult_base+i].executed = mult_prepared[i];
      rob_cand[mult_base+i].branch_taken = 1'b0;
      rob_cand[mult_base+i].target_addr = '0;
      bus_cand[mult_base+i] = '0;
      if (mult_prepared[i]) begin
        bus_cand[mult_base+i].dest_prn = mult_held[i].dest_prn;
        bus_cand[mult_base+i].value = mult_held[i].result;
      end
    end
    // alu lanes report their result as the target address
    for (int i = 0; i < num_fu_alu; i++) begin
      rob_cand[alu_base+i].robn = alu_held[i].robn;
      rob_cand[alu_base+i].executed = alu_prepared[i];
      rob_cand[alu_base+i].branch_taken = alu_held[i].take_branch;
      rob_cand[alu_base+i].target_addr = alu_held[i].result;
      bus_cand[alu_base+i] = '0;
      if (alu_prepared[i]) begin
        bus_cand[alu_base+i].dest_prn = alu_held[i].dest_prn;
        bus_cand[alu_base+i].value = alu_held[i].result;
      end
    end
  end

  // branch outcome straight out
  // whole packet zero when not valid
  always_comb begin
    for (int i = 0; i < num_fu_alu; i++) begin
      branch_packet[i] = '0;
      if (alu_prepared[i] && cond_branch[i]) begin
        branch_packet[i].valid = 1'b1;
        branch_packet[i].robn = alu_held[i].robn;
        branch_packet[i].take_branch = alu_held[i].take_branch;
        branch_packet[i].target = alu_held[i].result;
      end
    end
  end

  // one rob mux and one bus mux per port
  for (genvar k = 0; k < cdb_ports; k++) begin : g_port
    onehot_mux #(
      .WIDTH    (num_fu),
      .payload_t(fu_rob_packet_t)
    ) rob_mux_i (
      .in    (rob_cand),
      .select(gnt_bus[k]),
      .out   (fu_rob_packet[k])
    );

    onehot_mux #(
      .WIDTH    (num_fu),
      .payload_t(cdb_packet_t)
    ) bus_mux_i (
      .in    (bus_cand),
      .select(gnt_bus[k]),
      .out   (cdb_output[k])
    );
  end

endmodule

//--- logic/completion_stage.sv
`timescale 1ns/10ps

// completion stage top
// result slots per lane feeding the bus arbiter
module completion_stage import fu_packets_pkg::*; (
  input  logic clock,
  input  logic reset,
  input  logic [num_fu_alu-1:0] alu_in_valid,
  input  alu_result_t [num_fu_alu-1:0] alu_in,
  input  logic [num_fu_mult-1:0] mult_in_valid,
  input  fu_result_t [num_fu_mult-1:0] mult_in,
  input  logic [num_fu_load-1:0] load_in_valid,
  input  fu_result_t [num_fu_load-1:0] load_in,
  output logic [num_fu_alu-1:0] alu_avail,
  output logic [num_fu_mult-1:0] mult_avail,
  output logic [num_fu_load-1:0] load_avail,
  output branch_packet_t [num_fu_alu-1:0] branch_packet,
  output fu_rob_packet_t [cdb_ports-1:0] fu_rob_packet,
  output cdb_packet_t [cdb_ports-1:0] cdb_output
);

  // slot state toward the arbiter
  logic [num_fu_alu-1:0] alu_prepared;
  logic [num_fu_mult-1:0] mult_prepared;
  logic [num_fu_load-1:0] load_prepared;
  alu_result_t [num_fu_alu-1:0] alu_held;
  fu_result_t [num_fu_mult-1:0] mult_held;
  fu_result_t [num_fu_load-1:0] load_held;

  // alu lanes hold the wider packet with branch fields
  for (genvar i = 0; i < num_fu_alu; i++) begin : g_alu
    fu_result_slot #(
      .payload_t(alu_result_t)
    ) slot_i (
      .clock   (clock),
      .reset   (reset),
      .in_valid(alu_in_valid[i]),
      .in      (alu_in[i]),
      .avail   (alu_avail[i]),
      .prepared(alu_prepared[i]),
      .held    (alu_held[i])
    );
  end

  for (genvar i = 0; i < num_fu_mult; i++) begin : g_mult
    fu_result_slot #(
      .payload_t(fu_result_t)
    ) slot_i (
      .clock   (clock),
      .reset   (reset),
      .in_valid(mult_in_valid[i]),
      .in      (mult_in[i]),
      .avail   (mult_avail[i]),
      .prepared(mult_prepared[i]),
      .held    (mult_held[i])
    );
  end

  for (genvar i = 0; i < num_fu_load; i++) begin : g_load
    fu_result_slot #(
      .payload_t(fu_result_t)
    ) slot_i (
      .clock   (clock),
      .reset   (reset),
      .in_valid(load_in_valid[i]),
      .in      (load_in[i]),
      .avail   (load_avail[i]),
      .prepared(load_prepared[i]),
      .held    (load_held[i])
    );
  end

  // avail from here also gates the slot reloads
  cdb_arbiter arbiter_i (
    .alu_prepared (alu_prepared),
    .mult_prepared(mult_prepared),
    .load_prepared(load_prepared),
    .alu_held     (alu_held),
    .mult_held    (mult_held),
    .load_held    (load_held),
    .alu_avail    (alu_avail),
    .mult_avail   (mult_avail),
    .load_avail   (load_avail),
    .branch_packet(branch_packet),
    .fu_rob_packet(fu_rob_packet),
    .cdb_output   (cdb_output)
  );

endmodule

//--- logic/core_params_pkg.sv
package core_params_pkg;

  // machine-wide widths shared by every unit

  // data word, also the width of a branch target
  localparam int xlen = 32;

  // physical register file has 64 entries
  localparam int prn_width = 6;

  // reorder buffer has 32 entries
  localparam int rob_width = 5;

  // one data word or target address
  typedef logic [xlen-1:0] data_t;

  // index into the physical register file
  typedef logic [prn_width-1:0] prn_t;

  // index into the reorder buffer
  typedef logic [rob_width-1:0] robn_t;

endpackage

//--- logic/fu_packets_pkg.sv
package fu_packets_pkg;

  import core_params_pkg::*;

  // lanes per execution unit class
  localparam int num_fu_alu = 3;
  localparam int num_fu_mult = 2;
  localparam int num_fu_load = 2;
  localparam int num_fu = num_fu_alu + num_fu_mult + num_fu_load;

  // results broadcast per cycle
  localparam int cdb_ports = 2;

  // lane offsets in the bus request vector
  // load lanes sit lowest and win ties
  localparam int load_base = 0;
  localparam int mult_base = load_base + num_fu_load;
  localparam int alu_base = mult_base + num_fu_mult;

  // finished alu result
  // conditional branches carry their target in result
  typedef struct packed {
    robn_t robn;
    prn_t dest_prn;
    data_t result;
    logic cond_branch;
    logic take_branch;
  } alu_result_t;

  // finished multiplier or load result
  typedef struct packed {
    robn_t robn;
    prn_t dest_prn;
    data_t result;
  } fu_result_t;

  // one common data bus beat, read by the register file and the
  // reservation stations
  typedef struct packed {
    prn_t dest_prn;
    data_t value;
  } cdb_packet_t;

  // completion notice to the reorder buffer
  typedef struct packed {
    robn_t robn;
    logic executed;
    logic branch_taken;
    data_t target_addr;
  } fu_rob_packet_t;

  // branch outcome, bypasses the bus
  typedef struct packed {
    logic valid;
    robn_t robn;
    logic take_branch;
    data_t target;
  } branch_packet_t;

endpackage

//--- logic/fu_result_slot.sv
`timescale 1ns/10ps

// one lane's holding register between a unit and the bus
// reloads on every edge where avail is high
module fu_result_slot import fu_packets_pkg::*; #(
  parameter type payload_t = fu_result_t
) (
  input  logic clock,
  input  logic reset,
  input  logic in_valid,
  input  payload_t in,
  input  logic avail,
  output logic prepared,
  output payload_t held
);

  // occupancy flag
  // low avail means a waiting result, so hold it
  always_ff @(posedge clock) begin
    if (reset) begin
      prepared <= 1'b0;
    end else if (avail) begin
      prepared <= in_valid;
    end
  end

  // payload follows the same load enable
  // empty load writes zeros so an idle lane reads clean
  always_ff @(posedge clock) begin
    if (avail) begin
      if (in_valid) begin
        held <= in;
      end else begin
        held <= '0;
      end
    end
  end

endmodule

//--- logic/onehot_mux.sv
`timescale 1ns/10ps

// one-hot select over any packed payload
// zero out when no select bit is set
module onehot_mux import fu_packets_pkg::*; #(
  parameter int WIDTH = num_fu,
  parameter type payload_t = cdb_packet_t
) (
  input  payload_t [WIDTH-1:0] in,
  input  logic [WIDTH-1:0] select,
  output payload_t out
);

  // flat accumulator, ORed lane by lane
  logic [$bits(payload_t)-1:0] acc;

  always_comb begin
    acc = '0;
    for (int i = 0; i < WIDTH; i++) begin
      // replicate the select bit across the payload
      acc = acc | (in[i] & {$bits(payload_t){select[i]}});
    end
  end

  assign out = acc;

endmodule

//--- logic/psel_gen.sv
`timescale 1ns/10ps

// multi-grant priority selector
// index 0 is the highest priority
module psel_gen import fu_packets_pkg::*; #(
  parameter int WIDTH = num_fu,
  parameter int REQS = cdb_ports
) (
  input  logic [WIDTH-1:0] req,
  output logic [WIDTH-1:0] gnt,
  output logic [REQS-1:0][WIDTH-1:0] gnt_bus,
  output logic empty
);

  // requests not yet granted to an earlier port
  logic [WIDTH-1:0] remaining;

  // port k takes the lowest set bit left after ports 0..k-1
  always_comb begin
    remaining = req;
    for (int k = 0; k < REQS; k++) begin
      // isolate lowest set bit, two's complement trick
      gnt_bus[k] = remaining & (~remaining + 1'b1);
      // drop it so the next port sees the next request
      remaining = remaining & ~gnt_bus[k];
    end
  end

  // combined grant over all ports
  always_comb begin
    gnt = '0;
    for (int k = 0; k < REQS; k++) begin
      gnt = gnt | gnt_bus[k];
    end
  end

  // nothing requesting at all
  assign empty = ~|req;

endmodule

//--- sources.f
logic/core_params_pkg.sv
logic/fu_packets_pkg.sv
logic/psel_gen.sv
logic/onehot_mux.sv
logic/fu_result_slot.sv
logic/cdb_arbiter.sv
logic/completion_stage.sv
tests/completion_stage_tb.sv

//--- tests/completion_stage_tb.sv
`timescale 1ns/10ps

// completion stage testbench
// seeded random results into all seven lanes
// checked every cycle against a slot and priority model kept here
module completion_stage_tb import core_params_pkg::*, fu_packets_pkg::*; ();

  // stimulus length
  // timeout leaves margin for reset and drain
  localparam int stim_cycles = 1500;
  localparam int timeout_cycles = stim_cycles + 500;

  logic clock = 1'b0;
  logic reset;
  logic [num_fu_alu-1:0] alu_in_valid;
  alu_result_t [num_fu_alu-1:0] alu_in;
  logic [num_fu_mult-1:0] mult_in_valid;
  fu_result_t [num_fu_mult-1:0] mult_in;
  logic [num_fu_load-1:0] load_in_valid;
  fu_result_t [num_fu_load-1:0] load_in;
  logic [num_fu_alu-1:0] alu_avail;
  logic [num_fu_mult-1:0] mult_avail;
  logic [num_fu_load-1:0] load_avail;
  branch_packet_t [num_fu_alu-1:0] branch_packet;
  fu_rob_packet_t [cdb_ports-1:0] fu_rob_packet;
  cdb_packet_t [cdb_ports-1:0] cdb_output;

  // model slots in request-vector order
  // loads sit at index 0
  logic model_prep [num_fu];
  robn_t model_robn [num_fu];
  prn_t model_prn [num_fu];
  data_t model_val [num_fu];
  logic model_cond [num_fu];
  logic model_take [num_fu];
  logic [num_fu-1:0] model_avail;
  // lane granted to each port
  // -1 marks an idle port
  int port_lane [cdb_ports];

  // non-branch results issued but not yet broadcast
  logic pending [1 << rob_width];
  int issued = 0;
  int retired = 0;
  int cycle_count = 0;
  integer seed = 38;
  robn_t next_robn = '0;

  always #5 clock = ~clock;

  completion_stage dut_i (.*);

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  // true about once in n draws
  function automatic bit one_in(input int n);
    return (rand_word() % n) == 0;
  endfunction

  function automatic fu_result_t random_fu();
    fu_result_t r;
    logic [31:0] w;
    w = rand_word();
    r.robn = w[rob_width-1:0];
    r.dest_prn = w[8 +: prn_width];
    r.result = rand_word();
    return r;
  endfunction

  function automatic alu_result_t random_alu();
    alu_result_t r;
    fu_result_t f;
    logic [31:0] w;
    f = random_fu();
    w = rand_word();
    r.robn = f.robn;
    r.dest_prn = f.dest_prn;
    r.result = f.result;
    r.cond_branch = w[0];
    r.take_branch = w[1];
    return r;
  endfunction

  // hands out rob indices in order mod 32
  // an index still waiting for the bus is skipped, as a real rob would
  function automatic robn_t take_rob_index(input logic is_branch);
    robn_t r;
    while (pending[next_robn]) begin
      next_robn = next_robn + 1'b1;
    end
    r = next_robn;
    next_robn = next_robn + 1'b1;
    if (!is_branch) begin
      pending[r] = 1'b1;
      issued++;
    end
    return r;
  endfunction

  // slot reloads on avail and holds otherwise
  task automatic load_lane(input int lane, input logic valid, input robn_t robn, input prn_t prn,
                           input data_t val, input logic cond, input logic take);
    if (model_avail[lane]) begin
      model_prep[lane] = valid;
      model_robn[lane] = robn;
      model_prn[lane] = prn;
      model_val[lane] = val;
      model_cond[lane] = cond;
      model_take[lane] = take;
    end
  endtask

  task automatic update_model();
    for (int i = 0; i < num_fu_load; i++) begin
      load_lane(load_base + i, load_in_valid[i], load_in[i].robn, load_in[i].dest_prn,
                load_in[i].result, 1'b0, 1'b0);
    end
    for (int i = 0; i < num_fu_mult; i++) begin
      load_lane(mult_base + i, mult_in_valid[i], mult_in[i].robn, mult_in[i].dest_prn,
                mult_in[i].result, 1'b0, 1'b0);
    end
    for (int i = 0; i < num_fu_alu; i++) begin
      load_lane(alu_base + i, alu_in_valid[i], alu_in[i].robn, alu_in[i].dest_prn,
                alu_in[i].result, alu_in[i].cond_branch, alu_in[i].take_branch);
    end
  endtask

  // lowest pending non-branch lanes win the ports in order
  task automatic compute_model();
    int granted;
    logic [num_fu-1:0] gnt;
    granted = 0;
    gnt = '0;
    for (int k = 0; k < cdb_ports; k++) begin
      port_lane[k] = -1;
    end
    for (int i = 0; i < num_fu; i++) begin
      if (model_prep[i] && !model_cond[i] && granted < cdb_ports) begin
        gnt[i] = 1'b1;
        port_lane[granted] = i;
        granted++;
      end
    end
    for (int i = 0; i < num_fu; i++) begin
      model_avail[i] = gnt[i] | ~model_prep[i] | model_cond[i];
    end
  endtask

  // busy lanes get stray results that the slot must drop
  task automatic drive_inputs(input bit fill_all, input bit idle);
    for (int i = 0; i < num_fu_load; i++) begin
      load_in[i] = random_fu();
      load_in_valid[i] = model_avail[load_base + i] ? !idle && (fill_all || one_in(2)) : one_in(2);
      if (model_avail[load_base + i] && load_in_valid[i]) begin
        load_in[i].robn = take_rob_index(1'b0);
      end
    end
    for (int i = 0; i < num_fu_mult; i++) begin
      mult_in[i] = random_fu();
      mult_in_valid[i] = model_avail[mult_base + i] ? !idle && (fill_all || one_in(2)) : one_in(2);
      if (model_avail[mult_base + i] && mult_in_valid[i]) begin
        mult_in[i].robn = take_rob_index(1'b0);
      end
    end
    for (int i = 0; i < num_fu_alu; i++) begin
      alu_in[i] = random_alu();
      alu_in_valid[i] = model_avail[alu_base + i] ? !idle && (fill_all || one_in(2)) : one_in(2);
      if (model_avail[alu_base + i] && alu_in_valid[i]) begin
        alu_in[i].cond_branch = !fill_all && one_in(4);
        alu_in[i].robn = take_rob_index(alu_in[i].cond_branch);
      end
    end
  endtask

  task automatic check_outputs();
    cdb_packet_t exp_cdb;
    fu_rob_packet_t exp_rob;
    branch_packet_t exp_br;
    int lane;
    check_value("load_avail", 64'(load_avail), 64'(model_avail[load_base +: num_fu_load]));
    check_value("mult_avail", 64'(mult_avail), 64'(model_avail[mult_base +: num_fu_mult]));
    check_value("alu_avail", 64'(alu_avail), 64'(model_avail[alu_base +: num_fu_alu]));
    for (int k = 0; k < cdb_ports; k++) begin
      exp_cdb = '0;
      exp_rob = '0;
      lane = port_lane[k];
      if (lane >= 0) begin
        exp_cdb.dest_prn = model_prn[lane];
        exp_cdb.value = model_val[lane];
        exp_rob.robn = model_robn[lane];
        exp_rob.executed = 1'b1;
        // only alu lanes carry a target
        if (lane >= alu_base) begin
          exp_rob.branch_taken = model_take[lane];
          exp_rob.target_addr = model_val[lane];
        end
      end
      check_value($sformatf("cdb_output[%0d]", k), 64'(cdb_output[k]), 64'(exp_cdb));
      check_value($sformatf("fu_rob_packet[%0d]", k), 64'(fu_rob_packet[k]), 64'(exp_rob));
      if (fu_rob_packet[k].executed) begin
        if (!pending[fu_rob_packet[k].robn]) begin
          fail_run($sformatf("ROB index %0d reached the bus twice", fu_rob_packet[k].robn));
        end
        pending[fu_rob_packet[k].robn] = 1'b0;
        retired++;
      end
    end
    for (int i = 0; i < num_fu_alu; i++) begin
      exp_br = '0;
      if (model_prep[alu_base + i] && model_cond[alu_base + i]) begin
        exp_br.valid = 1'b1;
        exp_br.robn = model_robn[alu_base + i];
        exp_br.take_branch = model_take[alu_base + i];
        exp_br.target = model_val[alu_base + i];
      end
      check_value($sformatf("branch_packet[%0d]", i), 64'(branch_packet[i]), 64'(exp_br));
    end
  endtask

  // model update at the edge
  // drive 1 ns later and check mid-cycle
  task automatic step(input bit fill_all, input bit idle);
    @(posedge clock);
    update_model();
    #1;
    compute_model();
    drive_inputs(fill_all, idle);
    #4;
    check_outputs();
  endtask

  function automatic bit any_prepared();
    for (int i = 0; i < num_fu; i++) begin
      if (model_prep[i]) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      fail_run($sformatf("timeout, run still busy after %0d cycles", timeout_cycles));
    end
  end

  initial begin
    reset = 1'b1;
    alu_in_valid = '0;
    alu_in = '0;
    mult_in_valid = '0;
    mult_in = '0;
    load_in_valid = '0;
    load_in = '0;
    for (int i = 0; i < num_fu; i++) begin
      model_prep[i] = 1'b0;
      model_cond[i] = 1'b0;
    end
    for (int r = 0; r < (1 << rob_width); r++) begin
      pending[r] = 1'b0;
    end
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    // empty stage before any input
    compute_model();
    #4;
    check_outputs();
    // every 100th cycle fills all free lanes to force back-pressure
    for (int c = 0; c < stim_cycles; c++) begin
      step(c % 100 == 0, 1'b0);
    end
    step(1'b0, 1'b1);
    while (any_prepared()) begin
      step(1'b0, 1'b1);
    end
    check_value("retired_count", 64'(retired), 64'(issued));
    for (int r = 0; r < (1 << rob_width); r++) begin
      if (pending[r]) begin
        fail_run($sformatf("ROB index %0d never reached the bus", r));
      end
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule
